// File: ooo_pkg.sv
package ooo_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 48;

    typedef logic [XLEN-1:0]              data_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    // Sized for the largest ROB of 16 entries
    typedef logic [3:0]                   rob_idx_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLL  = 3'd5,
        OP_SRL  = 3'd6,
        OP_ADDI = 3'd7
    } alu_op_e;

    // ==================================================
    // Stage payloads
    // ==================================================
    typedef struct packed {
        alu_op_e   op;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        data_t     imm;
    } inst_t;

    typedef struct packed {
        alu_op_e   op;
        phys_reg_t dst;
        rob_idx_t  rob;
        data_t     src1;
        data_t     src2;
    } issue_t;

    // Qualified by a separate cdb_valid strobe
    typedef struct packed {
        phys_reg_t tag;
        rob_idx_t  rob;
        data_t     value;
    } cdb_t;

    typedef struct packed {
        arch_reg_t rd;
        logic      has_rd;
        data_t     value;
    } commit_t;

endpackage

// File: rename_map.sv
`timescale 1ns/1ps

module rename_map (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               accept,
    input  ooo_pkg::inst_t     inst,
    output ooo_pkg::phys_reg_t src1_tag,
    output ooo_pkg::phys_reg_t src2_tag,
    output ooo_pkg::phys_reg_t dst_tag,
    output ooo_pkg::phys_reg_t prev_tag,
    output logic               has_rd,
    output logic               free_empty,
    input  logic               retire,
    input  ooo_pkg::phys_reg_t retire_tag,
    input  logic               retire_has_rd
);

    // At most this many tags are ever off the alias table and out of flight
    localparam int FL_DEPTH = ooo_pkg::PHYS_REGS - ooo_pkg::ARCH_REGS;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);

    ooo_pkg::phys_reg_t  rat    [ooo_pkg::ARCH_REGS];
    ooo_pkg::phys_reg_t  free_q [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [FL_PTR_W:0]   fl_count;
    logic                pop;
    logic                push;

    function automatic logic [FL_PTR_W-1:0] next_ptr(input logic [FL_PTR_W-1:0] p);
        return (p == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // x0 is never renamed
    assign has_rd     = inst.rd != '0;
    assign pop        = accept && has_rd;
    assign push       = retire && retire_has_rd;
    assign free_empty = fl_count == '0;

    // Lookup sees the table before this instruction's own update
    assign src1_tag = rat[inst.rs1];
    assign src2_tag = rat[inst.rs2];
    assign prev_tag = rat[inst.rd];
    assign dst_tag  = has_rd ? free_q[fl_head] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
                rat[i] <= ooo_pkg::phys_reg_t'(i);
            end
            for (int k = 0; k < FL_DEPTH; k++) begin
                free_q[k] <= ooo_pkg::phys_reg_t'(ooo_pkg::ARCH_REGS + k);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (FL_PTR_W + 1)'(FL_DEPTH);
        end else begin
            if (pop) begin
                rat[inst.rd] <= free_q[fl_head];
                fl_head      <= next_ptr(fl_head);
            end
            // Old mapping comes back once its overwriter retires
            if (push) begin
                free_q[fl_tail] <= retire_tag;
                fl_tail         <= next_ptr(fl_tail);
            end
            fl_count <= fl_count + (FL_PTR_W + 1)'(push) - (FL_PTR_W + 1)'(pop);
        end
    end

endmodule

// File: phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  ooo_pkg::phys_reg_t rd_tag1,
    input  ooo_pkg::phys_reg_t rd_tag2,
    output ooo_pkg::data_t     rd_val1,
    output ooo_pkg::data_t     rd_val2,
    output logic               rd_rdy1,
    output logic               rd_rdy2,
    input  logic               alloc_en,
    input  ooo_pkg::phys_reg_t alloc_tag,
    input  logic               cdb_valid,
    input  ooo_pkg::cdb_t      cdb,
    input  ooo_pkg::phys_reg_t commit_tag,
    output ooo_pkg::data_t     commit_val
);

    ooo_pkg::data_t                regs [ooo_pkg::PHYS_REGS];
    logic [ooo_pkg::PHYS_REGS-1:0] ready;
    logic                          cdb_wr;

    // Results for x0 land on tag 0 and are dropped
    assign cdb_wr = cdb_valid && cdb.tag != '0;

    // Dispatch reads with bypass from this cycle's broadcast
    always_comb begin
        rd_val1 = regs[rd_tag1];
        rd_rdy1 = ready[rd_tag1];
        if (cdb_wr && cdb.tag == rd_tag1) begin
            rd_val1 = cdb.value;
            rd_rdy1 = 1'b1;
        end
        rd_val2 = regs[rd_tag2];
        rd_rdy2 = ready[rd_tag2];
        if (cdb_wr && cdb.tag == rd_tag2) begin
            rd_val2 = cdb.value;
            rd_rdy2 = 1'b1;
        end
    end

    assign commit_val = regs[commit_tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ooo_pkg::PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (cdb_wr) begin
                regs[cdb.tag]  <= cdb.value;
                ready[cdb.tag] <= 1'b1;
            end
            // New producer pending
            if (alloc_en) begin
                ready[alloc_tag] <= 1'b0;
            end
        end
    end

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int RS_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc_en,
    input  ooo_pkg::alu_op_e   alloc_op,
    input  ooo_pkg::phys_reg_t alloc_dst,
    input  ooo_pkg::rob_idx_t  alloc_rob,
    input  ooo_pkg::phys_reg_t src1_tag,
    input  ooo_pkg::phys_reg_t src2_tag,
    input  ooo_pkg::data_t     src1_val,
    input  ooo_pkg::data_t     src2_val,
    input  logic               src1_rdy,
    input  logic               src2_rdy,
    input  logic               cdb_valid,
    input  ooo_pkg::cdb_t      cdb,
    output logic               full,
    output logic               issue_valid,
    output ooo_pkg::issue_t    issue
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    typedef struct packed {
        ooo_pkg::alu_op_e   op;
        ooo_pkg::phys_reg_t dst;
        ooo_pkg::rob_idx_t  rob;
        ooo_pkg::phys_reg_t tag1;
        ooo_pkg::data_t     val1;
        logic               rdy1;
        ooo_pkg::phys_reg_t tag2;
        ooo_pkg::data_t     val2;
        logic               rdy2;
    } rs_entry_t;

    rs_entry_t            ent [RS_DEPTH];
    logic [RS_DEPTH-1:0]  valid;
    // Age is the number of older valid entries, so 0 is the oldest
    logic [IDX_W-1:0]     age [RS_DEPTH];
    logic [IDX_W-1:0]     alloc_slot;
    logic [IDX_W-1:0]     issue_slot;
    logic [IDX_W:0]       occupancy;

    assign full = &valid;

    // ==================================================
    // Slot pick and oldest-ready select
    // ==================================================
    always_comb begin
        alloc_slot  = '0;
        issue_slot  = '0;
        issue_valid = 1'b0;
        occupancy   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                alloc_slot = IDX_W'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            occupancy = occupancy + (IDX_W + 1)'(valid[i]);
            if (valid[i] && ent[i].rdy1 && ent[i].rdy2 &&
                (!issue_valid || age[i] < age[issue_slot])) begin
                issue_valid = 1'b1;
                issue_slot  = IDX_W'(i);
            end
        end
    end

    assign issue = '{op:   ent[issue_slot].op,
                     dst:  ent[issue_slot].dst,
                     rob:  ent[issue_slot].rob,
                     src1: ent[issue_slot].val1,
                     src2: ent[issue_slot].val2};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            // Younger entries move up when one leaves
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (issue_valid && valid[i] && age[i] > age[issue_slot]) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (issue_valid) begin
                valid[issue_slot] <= 1'b0;
            end
            if (alloc_en) begin
                valid[alloc_slot] <= 1'b1;
                age[alloc_slot]   <= IDX_W'(occupancy - (IDX_W + 1)'(issue_valid));
            end
        end
    end

    // ==================================================
    // Operand capture
    // ==================================================
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid && !ent[i].rdy1 && ent[i].tag1 == cdb.tag) begin
                ent[i].val1 <= cdb.value;
                ent[i].rdy1 <= 1'b1;
            end
            if (cdb_valid && !ent[i].rdy2 && ent[i].tag2 == cdb.tag) begin
                ent[i].val2 <= cdb.value;
                ent[i].rdy2 <= 1'b1;
            end
        end
        if (alloc_en) begin
            ent[alloc_slot] <= '{op: alloc_op, dst: alloc_dst, rob: alloc_rob,
                                 tag1: src1_tag, val1: src1_val, rdy1: src1_rdy,
                                 tag2: src2_tag, val2: src2_val, rdy2: src2_rdy};
        end
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  ooo_pkg::issue_t issue,
    output logic            cdb_valid,
    output ooo_pkg::cdb_t   cdb
);

    ooo_pkg::data_t result;

    always_comb begin
        case (issue.op)
            // Immediate already sits in the second source
            ooo_pkg::OP_ADD,
            ooo_pkg::OP_ADDI: result = issue.src1 + issue.src2;
            ooo_pkg::OP_SUB:  result = issue.src1 - issue.src2;
            ooo_pkg::OP_AND:  result = issue.src1 & issue.src2;
            ooo_pkg::OP_OR:   result = issue.src1 | issue.src2;
            ooo_pkg::OP_XOR:  result = issue.src1 ^ issue.src2;
            ooo_pkg::OP_SLL:  result = issue.src1 << issue.src2[4:0];
            ooo_pkg::OP_SRL:  result = issue.src1 >> issue.src2[4:0];
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    // Broadcast one cycle after issue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb <= '{tag: issue.dst, rob: issue.rob, value: result};
        end
    end

endmodule

// File: rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int ROB_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc_en,
    input  ooo_pkg::arch_reg_t alloc_rd,
    input  logic               alloc_has_rd,
    input  ooo_pkg::phys_reg_t alloc_tag,
    input  ooo_pkg::phys_reg_t alloc_prev,
    output ooo_pkg::rob_idx_t  alloc_idx,
    output logic               full,
    input  logic               cdb_valid,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::phys_reg_t commit_tag,
    input  ooo_pkg::data_t     commit_val,
    output logic               retire,
    output ooo_pkg::phys_reg_t retire_tag,
    output logic               retire_has_rd,
    output logic               commit_valid,
    output ooo_pkg::commit_t   commit
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    typedef struct packed {
        ooo_pkg::arch_reg_t rd;
        logic               has_rd;
        ooo_pkg::phys_reg_t tag;
        ooo_pkg::phys_reg_t prev;
    } rob_entry_t;

    rob_entry_t          ent [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;
    ooo_pkg::rob_idx_t   head;
    ooo_pkg::rob_idx_t   tail;
    logic [CNT_W-1:0]    count;

    function automatic ooo_pkg::rob_idx_t next_idx(input ooo_pkg::rob_idx_t p);
        return (p == ooo_pkg::rob_idx_t'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = count == CNT_W'(ROB_DEPTH);
    assign alloc_idx = tail;

    // Retire the head as soon as its result is in
    assign retire        = count != '0 && done[head];
    assign commit_valid  = retire;
    assign commit_tag    = ent[head].tag;
    assign retire_tag    = ent[head].prev;
    assign retire_has_rd = ent[head].has_rd;
    assign commit = '{rd: ent[head].rd, has_rd: ent[head].has_rd, value: commit_val};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_en) begin
                done[tail] <= 1'b0;
                tail       <= next_idx(tail);
            end
            if (cdb_valid) begin
                done[cdb.rob] <= 1'b1;
            end
            if (retire) begin
                head <= next_idx(head);
            end
            count <= count + CNT_W'(alloc_en) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent[tail] <= '{rd: alloc_rd, has_rd: alloc_has_rd,
                           tag: alloc_tag, prev: alloc_prev};
        end
    end

endmodule

// File: ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top #(
    parameter int ROB_DEPTH = 16,
    parameter int RS_DEPTH  = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  ooo_pkg::inst_t   in_inst,
    output logic             dispatch_stall,
    output logic             commit_valid,
    output ooo_pkg::commit_t commit
);

    logic               accept;
    logic               is_addi;
    ooo_pkg::phys_reg_t src1_tag;
    ooo_pkg::phys_reg_t src2_tag;
    ooo_pkg::phys_reg_t dst_tag;
    ooo_pkg::phys_reg_t prev_tag;
    logic               has_rd;
    logic               free_empty;
    ooo_pkg::data_t     rd_val1;
    ooo_pkg::data_t     rd_val2;
    logic               rd_rdy1;
    logic               rd_rdy2;
    logic               rs_full;
    logic               rob_full;
    ooo_pkg::rob_idx_t  rob_idx;
    logic               issue_valid;
    ooo_pkg::issue_t    issue;
    logic               cdb_valid;
    ooo_pkg::cdb_t      cdb;
    ooo_pkg::phys_reg_t commit_tag;
    ooo_pkg::data_t     commit_val;
    logic               retire;
    ooo_pkg::phys_reg_t retire_tag;
    logic               retire_has_rd;

    // ==================================================
    // Dispatch control
    // ==================================================
    // Stall comes from stage state only, never from in_valid
    assign dispatch_stall = rob_full | free_empty | rs_full;
    assign accept         = in_valid & ~dispatch_stall;
    assign is_addi        = in_inst.op == ooo_pkg::OP_ADDI;

    rename_map u_rename_map (
        .clk(clk), .rst_n(rst_n),
        .accept(accept), .inst(in_inst),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .dst_tag(dst_tag), .prev_tag(prev_tag),
        .has_rd(has_rd), .free_empty(free_empty),
        .retire(retire), .retire_tag(retire_tag), .retire_has_rd(retire_has_rd)
    );

    phys_regfile u_phys_regfile (
        .clk(clk), .rst_n(rst_n),
        .rd_tag1(src1_tag), .rd_tag2(src2_tag),
        .rd_val1(rd_val1), .rd_val2(rd_val2),
        .rd_rdy1(rd_rdy1), .rd_rdy2(rd_rdy2),
        .alloc_en(accept && has_rd), .alloc_tag(dst_tag),
        .cdb_valid(cdb_valid), .cdb(cdb),
        .commit_tag(commit_tag), .commit_val(commit_val)
    );

    // ==================================================
    // Execute
    // ==================================================
    // Immediate enters as an already captured second operand
    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_reservation_station (
        .clk(clk), .rst_n(rst_n),
        .alloc_en(accept), .alloc_op(in_inst.op),
        .alloc_dst(dst_tag), .alloc_rob(rob_idx),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_val(rd_val1), .src2_val(is_addi ? in_inst.imm : rd_val2),
        .src1_rdy(rd_rdy1), .src2_rdy(is_addi | rd_rdy2),
        .cdb_valid(cdb_valid), .cdb(cdb),
        .full(rs_full),
        .issue_valid(issue_valid), .issue(issue)
    );

    alu u_alu (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue(issue),
        .cdb_valid(cdb_valid), .cdb(cdb)
    );

    // ==================================================
    // Retire
    // ==================================================
    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk(clk), .rst_n(rst_n),
        .alloc_en(accept), .alloc_rd(in_inst.rd), .alloc_has_rd(has_rd),
        .alloc_tag(dst_tag), .alloc_prev(prev_tag),
        .alloc_idx(rob_idx), .full(rob_full),
        .cdb_valid(cdb_valid), .cdb(cdb),
        .commit_tag(commit_tag), .commit_val(commit_val),
        .retire(retire), .retire_tag(retire_tag), .retire_has_rd(retire_has_rd),
        .commit_valid(commit_valid), .commit(commit)
    );

endmodule

// File: tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int NUM_INSTS   = 32;
    // Instructions from here on are sent back to back
    localparam int BURST_START = 8;
    localparam int STALL_LIMIT = 200;
    localparam int DRAIN_LIMIT = 2000;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    ooo_pkg::inst_t   in_inst;
    logic             dispatch_stall;
    logic             commit_valid;
    ooo_pkg::commit_t commit;

    // Six words per instruction: op rd rs1 rs2 imm expected
    logic [31:0] stim_mem [6*NUM_INSTS];
    int          commit_idx;
    int          error_count;
    int          stall_cycles;
    logic        timed_out;

    ooo_core_top u_ooo_core_top (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_inst(in_inst),
        .dispatch_stall(dispatch_stall),
        .commit_valid(commit_valid), .commit(commit)
    );

    always #4 clk = ~clk;

    function automatic ooo_pkg::inst_t inst_at(input int n);
        ooo_pkg::inst_t inst;
        inst.op  = ooo_pkg::alu_op_e'(stim_mem[6*n][2:0]);
        inst.rd  = stim_mem[6*n+1][4:0];
        inst.rs1 = stim_mem[6*n+2][4:0];
        inst.rs2 = stim_mem[6*n+3][4:0];
        inst.imm = stim_mem[6*n+4];
        return inst;
    endfunction

    task automatic check_field(input string name, input int n,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s[%0d]: expected %h, actual %h", name, n, expected, actual);
            error_count++;
        end
    endtask

    // Holds the instruction until an edge without stall takes it
    task automatic send_inst(input int n);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_inst  = inst_at(n);
        while (dispatch_stall && waited < STALL_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
            stall_cycles++;
        end
        assert (!dispatch_stall) else begin
            $display("ERROR: instruction %0d was never accepted, stall held %0d cycles",
                     n, STALL_LIMIT);
            error_count++;
            timed_out = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_commits();
        int waited;
        waited = 0;
        while (commit_idx < NUM_INSTS && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (commit_idx >= NUM_INSTS) else begin
            $display("ERROR: timed out waiting for the last commit, %0d of %0d seen",
                     commit_idx, NUM_INSTS);
            error_count++;
        end
    endtask

    // ==================================================
    // Commit checker, sampled mid-cycle
    // ==================================================
    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            assert (commit_idx < NUM_INSTS) else begin
                $display("ERROR: extra commit after the last instruction, rd %0d value %h",
                         commit.rd, commit.value);
                error_count++;
            end
            if (commit_idx < NUM_INSTS) begin
                check_field("commit_rd", commit_idx, stim_mem[6*commit_idx+1][4:0], commit.rd);
                check_field("commit_has_rd", commit_idx,
                            stim_mem[6*commit_idx+1][4:0] != 5'd0, commit.has_rd);
                check_field("commit_value", commit_idx, stim_mem[6*commit_idx+5], commit.value);
            end
            commit_idx++;
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        int gap;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_inst      = '0;
        commit_idx   = 0;
        error_count  = 0;
        stall_cycles = 0;
        timed_out    = 1'b0;
        void'($urandom(22));
        $readmemh("ooo_core_input.txt", stim_mem);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Core must come out of reset idle
        repeat (3) begin
            @(posedge clk);
            #1;
            check_field("idle_commit_valid", 0, 32'd0, commit_valid);
            check_field("idle_dispatch_stall", 0, 32'd0, dispatch_stall);
        end

        for (int n = 0; n < NUM_INSTS && !timed_out; n++) begin
            if (n < BURST_START) begin
                gap      = $urandom % 4;
                in_valid = 1'b0;
                repeat (gap) @(posedge clk);
                #1;
            end
            send_inst(n);
        end
        in_valid = 1'b0;

        // The back-to-back burst has to run into back-pressure
        assert (stall_cycles > 0) else begin
            $display("ERROR: dispatch_stall never rose, no instruction was held");
            error_count++;
        end

        if (!timed_out) begin
            wait_for_commits();
        end
        // Quiet window to catch duplicated commits
        repeat (20) @(posedge clk);
        check_field("commit_count", 0, NUM_INSTS, commit_idx);

        $display("Errors: %0d, commits: %0d of %0d, stall cycles: %0d",
                 error_count, commit_idx, NUM_INSTS, stall_cycles);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: ooo_core_input.txt
// Instruction stream for tb_ooo_core, every field in hex
// Columns: op rd rs1 rs2 imm expected (op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 addi)
7 01 00 00 00000005 00000005 // addi x1, x0, 5
7 02 00 00 0000000c 0000000c // addi x2, x0, 12
0 03 01 02 00000000 00000011 // add  x3, x1, x2
1 04 02 01 00000000 00000007 // sub  x4, x2, x1
4 05 03 04 00000000 00000016 // xor  x5, x3, x4
5 06 04 01 00000000 000000e0 // sll  x6, x4, x1
7 00 06 00 00000063 00000000 // addi x0, x6, 99
3 07 00 06 00000000 000000e0 // or   x7, x0, x6
6 08 06 01 00000000 00000007 // srl  x8, x6, x1 (burst starts)
7 09 00 00 fffffff0 fffffff0 // addi x9, x0, -16
2 0a 09 06 00000000 000000e0 // and  x10, x9, x6
0 01 01 02 00000000 00000011 // add  x1, x1, x2
0 02 01 02 00000000 0000001d // add  x2, x1, x2
0 03 01 02 00000000 0000002e // add  x3, x1, x2
0 01 02 03 00000000 0000004b // add  x1, x2, x3
0 02 03 01 00000000 00000079 // add  x2, x3, x1
0 03 01 02 00000000 000000c4 // add  x3, x1, x2
1 01 03 02 00000000 0000004b // sub  x1, x3, x2
4 02 01 03 00000000 0000008f // xor  x2, x1, x3
7 03 03 00 00000100 000001c4 // addi x3, x3, 256
3 01 02 03 00000000 000001cf // or   x1, x2, x3
6 02 01 04 00000000 00000003 // srl  x2, x1, x4
5 03 01 02 00000000 00000e78 // sll  x3, x1, x2
0 01 03 01 00000000 00001047 // add  x1, x3, x1
1 02 02 01 00000000 ffffefbc // sub  x2, x2, x1
2 03 02 09 00000000 ffffefb0 // and  x3, x2, x9
7 01 02 00 00001044 00000000 // addi x1, x2, 0x1044
0 02 03 00 00000000 ffffefb0 // add  x2, x3, x0
4 03 03 02 00000000 00000000 // xor  x3, x3, x2
7 01 03 00 00000001 00000001 // addi x1, x3, 1
0 00 01 01 00000000 00000000 // add  x0, x1, x1
0 02 00 01 00000000 00000001 // add  x2, x0, x1

// File: ooo_core.f
ooo_pkg.sv
rename_map.sv
phys_regfile.sv
reservation_station.sv
alu.sv
rob.sv
ooo_core_top.sv
tb_ooo_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_core -f ooo_core.f
sim_out=$(./obj_dir/Vtb_ooo_core)
echo "$sim_out"
echo "$sim_out" | grep -q "^=== PASS ===$"
